//--- lite_macros.svh
`ifndef LITE_MACROS_SVH
`define LITE_MACROS_SVH

// masters sharing the register bank
`define LITE_NUM_MASTERS 4

// bits needed to name one master
`define LITE_IDX_W 2

// byte address width on every master port
`define LITE_ADDR_W 8

// data bus width, strobe width follows as one bit per byte
`define LITE_DATA_W 32

// register count, word address bits 5..2 pick one
// anything above that range is a decode error
`define LITE_REG_DEPTH 16

`endif

//--- lite_pkg.sv
`include "lite_macros.svh"

package lite_pkg;

	// widths with a meaning
	typedef logic [`LITE_ADDR_W-1:0] addr_t;
	typedef logic [`LITE_DATA_W-1:0] data_t;
	typedef logic [`LITE_DATA_W/8-1:0] strb_t;
	typedef logic [1:0] resp_t;
	typedef logic [`LITE_NUM_MASTERS-1:0] port_vec_t;
	typedef logic [`LITE_IDX_W-1:0] port_idx_t;
	typedef logic [$clog2(`LITE_REG_DEPTH)-1:0] reg_idx_t;

	// axi response codes in use
	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// everything one master drives
	typedef struct packed {
		logic awvalid;
		addr_t awaddr;
		logic wvalid;
		data_t wdata;
		strb_t wstrb;
		logic bready;
		logic arvalid;
		addr_t araddr;
		logic rready;
	} lite_req_t;

	// everything one master receives
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		resp_t bresp;
		logic arready;
		logic rvalid;
		data_t rdata;
		resp_t rresp;
	} lite_rsp_t;

	// write command into the bank
	typedef struct packed {
		logic en;
		addr_t addr;
		data_t data;
		strb_t strb;
	} bank_wr_t;

	// read command into the bank
	typedef struct packed {
		logic en;
		addr_t addr;
	} bank_rd_t;

	// bank answers, bresp is combinational, rdata/rresp registered
	typedef struct packed {
		resp_t bresp;
		data_t rdata;
		resp_t rresp;
	} bank_rsp_t;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_COMMIT,
		WR_RESP
	} wr_state_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_FETCH,
		RD_RESP
	} rd_state_t;

endpackage

//--- rr_sch.sv
`timescale 1ns/1ns
`include "lite_macros.svh"

module rr_sch
	import lite_pkg::*;
#(
	parameter int num_port = `LITE_NUM_MASTERS
) (
	input  logic clk,
	input  logic rst_n,
	input  port_vec_t req,
	input  logic stall,
	output port_vec_t grant
);

	localparam int idx_w = (num_port > 1) ? $clog2(num_port) : 1;

	// rank of each port, num_port-1 is served first
	logic [idx_w-1:0] rank [num_port];
	// one bit per rank that has a live request behind it
	logic [num_port-1:0] busy_rank;
	logic [num_port-1:0] grant_vec;
	// grant encoded back to a port number
	logic [idx_w-1:0] sch_index;

	// collect ranks held by requesting ports
	always_comb begin
		busy_rank = '0;
		for (int i = 0; i < num_port; i++) begin
			if (req[i]) begin
				busy_rank = busy_rank | (num_port'(1) << rank[i]);
			end
		end
	end

	// a requester wins when no busy rank sits above its own
	always_comb begin
		for (int i = 0; i < num_port; i++) begin
			grant_vec[i] = req[i] &
				~|(busy_rank & ({num_port{1'b1}} << (int'(rank[i]) + 1)));
		end
	end

	// one-hot to index
	always_comb begin
		sch_index = '0;
		for (int i = 0; i < num_port; i++) begin
			if (grant_vec[i]) begin
				sch_index = idx_w'(i);
			end
		end
	end

	// after granting s, port s+1 takes the top rank, s drops to zero
	// reset state matches port 0 just granted
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < num_port; i++) begin
				rank[i] <= idx_w'((num_port - i) % num_port);
			end
		end else if (!stall && (|req)) begin
			for (int i = 0; i < num_port; i++) begin
				rank[i] <= idx_w'((int'(sch_index) + num_port - i) % num_port);
			end
		end
	end

	assign grant = grant_vec;

endmodule

//--- wr_path.sv
`timescale 1ns/1ns
`include "lite_macros.svh"

module wr_path
	import lite_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  lite_req_t [`LITE_NUM_MASTERS-1:0] mst_req,
	output lite_rsp_t [`LITE_NUM_MASTERS-1:0] wr_rsp,
	output bank_wr_t bank_wr,
	input  resp_t bresp_in
);

	wr_state_t state;
	// masters with address and data both valid
	port_vec_t wr_req;
	port_vec_t grant;
	port_idx_t grant_idx;
	// master that owns the transaction in flight
	port_idx_t owner;
	addr_t addr_q;
	data_t data_q;
	strb_t strb_q;
	resp_t bresp_q;
	logic take;
	logic b_done;

	// aw and w must arrive together
	always_comb begin
		for (int i = 0; i < `LITE_NUM_MASTERS; i++) begin
			wr_req[i] = mst_req[i].awvalid & mst_req[i].wvalid;
		end
	end

	// no new grant while a write is in flight
	rr_sch u_sch (
		.clk(clk),
		.rst_n(rst_n),
		.req(wr_req),
		.stall(state != WR_IDLE),
		.grant(grant)
	);

	// mux select for the capture
	always_comb begin
		grant_idx = '0;
		for (int i = 0; i < `LITE_NUM_MASTERS; i++) begin
			if (grant[i]) begin
				grant_idx = port_idx_t'(i);
			end
		end
	end

	assign take = (state == WR_IDLE) && (|grant);
	assign b_done = (state == WR_RESP) && mst_req[owner].bready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= WR_IDLE;
			owner <= '0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (take) begin
						state <= WR_COMMIT;
						owner <= grant_idx;
					end
				end
				// bank write happens here, one cycle only
				WR_COMMIT: state <= WR_RESP;
				// wait out bready
				WR_RESP: begin
					if (b_done) begin
						state <= WR_IDLE;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	// payload, only read once the fsm says it is valid
	always_ff @(posedge clk) begin
		if (take) begin
			addr_q <= mst_req[grant_idx].awaddr;
			data_q <= mst_req[grant_idx].wdata;
			strb_q <= mst_req[grant_idx].wstrb;
		end
		// bank decode answer for this address
		if (state == WR_COMMIT) begin
			bresp_q <= bresp_in;
		end
	end

	always_comb begin
		bank_wr.en = (state == WR_COMMIT);
		bank_wr.addr = addr_q;
		bank_wr.data = data_q;
		bank_wr.strb = strb_q;
	end

	// only write-side fields, the read path fills the rest
	always_comb begin
		for (int i = 0; i < `LITE_NUM_MASTERS; i++) begin
			wr_rsp[i] = '0;
			wr_rsp[i].awready = take && grant[i];
			wr_rsp[i].wready = take && grant[i];
			wr_rsp[i].bvalid = (state == WR_RESP) && (owner == port_idx_t'(i));
			wr_rsp[i].bresp = wr_rsp[i].bvalid ? bresp_q : RESP_OKAY;
		end
	end

endmodule

//--- rd_path.sv
`timescale 1ns/1ns
`include "lite_macros.svh"

module rd_path
	import lite_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  lite_req_t [`LITE_NUM_MASTERS-1:0] mst_req,
	output lite_rsp_t [`LITE_NUM_MASTERS-1:0] rd_rsp,
	output bank_rd_t bank_rd,
	input  data_t rdata_in,
	input  resp_t rresp_in
);

	rd_state_t state;
	port_vec_t rd_req;
	port_vec_t grant;
	port_idx_t grant_idx;
	port_idx_t owner;
	addr_t addr_q;
	logic take;
	logic r_done;

	always_comb begin
		for (int i = 0; i < `LITE_NUM_MASTERS; i++) begin
			rd_req[i] = mst_req[i].arvalid;
		end
	end

	// stalled for the whole fetch and response
	rr_sch u_sch (
		.clk(clk),
		.rst_n(rst_n),
		.req(rd_req),
		.stall(state != RD_IDLE),
		.grant(grant)
	);

	always_comb begin
		grant_idx = '0;
		for (int i = 0; i < `LITE_NUM_MASTERS; i++) begin
			if (grant[i]) begin
				grant_idx = port_idx_t'(i);
			end
		end
	end

	assign take = (state == RD_IDLE) && (|grant);
	assign r_done = (state == RD_RESP) && mst_req[owner].rready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= RD_IDLE;
			owner <= '0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (take) begin
						state <= RD_FETCH;
						owner <= grant_idx;
					end
				end
				// bank registers the word this cycle
				RD_FETCH: state <= RD_RESP;
				RD_RESP: begin
					if (r_done) begin
						state <= RD_IDLE;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			addr_q <= mst_req[grant_idx].araddr;
		end
	end

	assign bank_rd.en = (state == RD_FETCH);
	assign bank_rd.addr = addr_q;

	// bank output register only moves on a fetch, so it holds through resp
	always_comb begin
		for (int i = 0; i < `LITE_NUM_MASTERS; i++) begin
			rd_rsp[i] = '0;
			rd_rsp[i].arready = take && grant[i];
			rd_rsp[i].rvalid = (state == RD_RESP) && (owner == port_idx_t'(i));
			rd_rsp[i].rdata = rd_rsp[i].rvalid ? rdata_in : '0;
			rd_rsp[i].rresp = rd_rsp[i].rvalid ? rresp_in : RESP_OKAY;
		end
	end

endmodule

//--- reg_bank.sv
`timescale 1ns/1ns
`include "lite_macros.svh"

module reg_bank
	import lite_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  bank_wr_t bank_wr,
	input  bank_rd_t bank_rd,
	output bank_rsp_t bank_rsp
);

	data_t regs [`LITE_REG_DEPTH];
	// word addresses, byte offset dropped
	logic [`LITE_ADDR_W-3:0] wr_word;
	logic [`LITE_ADDR_W-3:0] rd_word;
	reg_idx_t wr_idx;
	reg_idx_t rd_idx;
	logic wr_hit;
	logic rd_hit;
	data_t rdata_q;
	resp_t rresp_q;

	assign wr_word = bank_wr.addr[`LITE_ADDR_W-1:2];
	assign rd_word = bank_rd.addr[`LITE_ADDR_W-1:2];
	assign wr_idx = wr_word[$bits(reg_idx_t)-1:0];
	assign rd_idx = rd_word[$bits(reg_idx_t)-1:0];
	// upper address bits must be zero
	assign wr_hit = (wr_word < `LITE_REG_DEPTH);
	assign rd_hit = (rd_word < `LITE_REG_DEPTH);

	// byte lanes follow wstrb, misses leave the array alone
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int r = 0; r < `LITE_REG_DEPTH; r++) begin
				regs[r] <= '0;
			end
		end else if (bank_wr.en && wr_hit) begin
			for (int b = 0; b < $bits(strb_t); b++) begin
				if (bank_wr.strb[b]) begin
					regs[wr_idx][8*b +: 8] <= bank_wr.data[8*b +: 8];
				end
			end
		end
	end

	// same-cycle write to this register is seen by the next read only
	always_ff @(posedge clk) begin
		if (bank_rd.en) begin
			rdata_q <= rd_hit ? regs[rd_idx] : '0;
			rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

	assign bank_rsp.bresp = wr_hit ? RESP_OKAY : RESP_SLVERR;
	assign bank_rsp.rdata = rdata_q;
	assign bank_rsp.rresp = rresp_q;

endmodule

//--- lite_arb_top.sv
`timescale 1ns/1ns
`include "lite_macros.svh"

module lite_arb_top
	import lite_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  lite_req_t [`LITE_NUM_MASTERS-1:0] mst_req,
	output lite_rsp_t [`LITE_NUM_MASTERS-1:0] mst_rsp
);

	// per-path responses, each zero outside its own fields
	lite_rsp_t [`LITE_NUM_MASTERS-1:0] wr_rsp;
	lite_rsp_t [`LITE_NUM_MASTERS-1:0] rd_rsp;
	bank_wr_t bank_wr;
	bank_rd_t bank_rd;
	bank_rsp_t bank_rsp;

	// aw + w + b
	wr_path u_wr_path (
		.clk(clk),
		.rst_n(rst_n),
		.mst_req(mst_req),
		.wr_rsp(wr_rsp),
		.bank_wr(bank_wr),
		.bresp_in(bank_rsp.bresp)
	);

	// ar + r
	rd_path u_rd_path (
		.clk(clk),
		.rst_n(rst_n),
		.mst_req(mst_req),
		.rd_rsp(rd_rsp),
		.bank_rd(bank_rd),
		.rdata_in(bank_rsp.rdata),
		.rresp_in(bank_rsp.rresp)
	);

	// shared storage for both paths
	reg_bank u_reg_bank (
		.clk(clk),
		.rst_n(rst_n),
		.bank_wr(bank_wr),
		.bank_rd(bank_rd),
		.bank_rsp(bank_rsp)
	);

	// fields never overlap, a plain or merges them
	assign mst_rsp = wr_rsp | rd_rsp;

endmodule

//--- tb_lite_arb.sv
`timescale 1ns/1ns
`include "lite_macros.svh"

module tb_lite_arb
	import lite_pkg::*;
();

	localparam int nm = `LITE_NUM_MASTERS;
	// one full transfer costs at most this many cycles
	localparam int op_cycles = 8;
	// transfers per test plus hold cycles of the stalled reads
	localparam int test_cycles = 4 + op_cycles * (16 + 32 + 6 + 18 + 5 + 6) + (3 + 1 + 4 + 2);

	logic clk;
	logic rst_n;
	lite_req_t [nm-1:0] mst_req;
	lite_rsp_t [nm-1:0] mst_rsp;

	// expected register contents
	data_t model [`LITE_REG_DEPTH];
	logic [31:0] lfsr;
	int errs;
	int tests;
	// last granted master per path (reset acts as master 0)
	port_idx_t last_wr;
	port_idx_t last_rd;
	port_idx_t wr_order [$];
	port_idx_t rd_order [$];

	lite_arb_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.mst_req(mst_req),
		.mst_rsp(mst_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (2 * test_cycles) @(posedge clk);
		$display("timeout: tests still running after %0d cycles", 2 * test_cycles);
		$display("Test failed");
		$finish;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one step per bit taken
	function automatic data_t rand_bits(input int n);
		data_t w;
		w = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[30:0], lfsr[0]};
		end
		return w;
	endfunction

	// bits 7..6 clear means in range and bits 5..2 pick the word
	function automatic void model_write(input addr_t a, input data_t d, input strb_t s);
		if (a[7:6] == 2'b00) begin
			for (int b = 0; b < 4; b++) begin
				if (s[b]) begin
					model[a[5:2]][8*b +: 8] = d[8*b +: 8];
				end
			end
		end
	endfunction

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s data %h, expected %h", $time, what, got, exp);
			errs++;
		end
	endtask

	task automatic verify_resp(input resp_t got, input resp_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s resp %0d, expected %0d", $time, what, got, exp);
			errs++;
		end
	endtask

	task automatic expect_idx(input port_idx_t got, input port_idx_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s master %0d, expected %0d", $time, what, got, exp);
			errs++;
		end
	endtask

	// all handshake outputs of one master low
	task automatic idle_outputs(input int m);
		logic [4:0] hs;
		hs = {mst_rsp[m].awready, mst_rsp[m].wready, mst_rsp[m].bvalid,
			mst_rsp[m].arready, mst_rsp[m].rvalid};
		if (hs !== 5'b0) begin
			$display("ERR %0t ns: master %0d handshakes %b, expected 0", $time, m, hs);
			errs++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		$display("%s: %0d mismatches", name, errs - errs_before);
	endtask

	// aw and w presented together with bready held high
	task automatic write_txn(input int m, input addr_t a, input data_t d, input strb_t s,
		output resp_t r);
		@(posedge clk);
		mst_req[m].awvalid <= 1'b1;
		mst_req[m].awaddr <= a;
		mst_req[m].wvalid <= 1'b1;
		mst_req[m].wdata <= d;
		mst_req[m].wstrb <= s;
		mst_req[m].bready <= 1'b1;
		do begin
			@(negedge clk);
		end while (!mst_rsp[m].awready);
		// both readies rise in the same cycle
		if (mst_rsp[m].wready !== 1'b1) begin
			$display("ERR %0t ns: master %0d wready %b with awready, expected 1",
				$time, m, mst_rsp[m].wready);
			errs++;
		end
		last_wr = port_idx_t'(m);
		@(posedge clk);
		mst_req[m].awvalid <= 1'b0;
		mst_req[m].wvalid <= 1'b0;
		do begin
			@(negedge clk);
		end while (!mst_rsp[m].bvalid);
		r = mst_rsp[m].bresp;
		wr_order.push_back(port_idx_t'(m));
		model_write(a, d, s);
		@(posedge clk);
		mst_req[m].bready <= 1'b0;
	endtask

	// rready stays low for hold cycles after rvalid
	task automatic read_txn(input int m, input addr_t a, input int hold,
		output data_t d, output resp_t r);
		@(posedge clk);
		mst_req[m].arvalid <= 1'b1;
		mst_req[m].araddr <= a;
		do begin
			@(negedge clk);
		end while (!mst_rsp[m].arready);
		last_rd = port_idx_t'(m);
		rd_order.push_back(port_idx_t'(m));
		@(posedge clk);
		mst_req[m].arvalid <= 1'b0;
		do begin
			@(negedge clk);
		end while (!mst_rsp[m].rvalid);
		repeat (hold) @(posedge clk);
		@(posedge clk);
		mst_req[m].rready <= 1'b1;
		@(negedge clk);
		if (!mst_rsp[m].rvalid) begin
			$display("master %0d lost rvalid while rready was low", m);
			errs++;
		end
		d = mst_rsp[m].rdata;
		r = mst_rsp[m].rresp;
		@(posedge clk);
		mst_req[m].rready <= 1'b0;
	endtask

	task automatic test_reset();
		int e0;
		data_t d;
		resp_t r;
		e0 = errs;
		@(negedge clk);
		for (int m = 0; m < nm; m++) begin
			idle_outputs(m);
		end
		for (int i = 0; i < `LITE_REG_DEPTH; i++) begin
			read_txn(i % nm, addr_t'(4 * i), 0, d, r);
			check_data(d, '0, "reset read");
			verify_resp(r, RESP_OKAY, "reset read");
		end
		report_test("reset state", e0);
	endtask

	// write all registers with masters in turn and read back through another master
	task automatic test_fill();
		int e0;
		data_t d;
		resp_t r;
		e0 = errs;
		for (int i = 0; i < `LITE_REG_DEPTH; i++) begin
			write_txn(i % nm, addr_t'(4 * i), rand_bits(32), 4'hf, r);
			verify_resp(r, RESP_OKAY, "fill write");
		end
		for (int i = 0; i < `LITE_REG_DEPTH; i++) begin
			read_txn((i + 1) % nm, addr_t'(4 * i), 0, d, r);
			check_data(d, model[i], "fill read");
			verify_resp(r, RESP_OKAY, "fill read");
		end
		report_test("fill and read back", e0);
	endtask

	task automatic test_strobes();
		int e0;
		data_t d;
		resp_t r;
		strb_t s;
		e0 = errs;
		for (int k = 0; k < 3; k++) begin
			s = (k == 0) ? 4'b0001 : (k == 1) ? 4'b0110 : 4'b1000;
			write_txn(k, 8'h14, rand_bits(32), s, r);
			verify_resp(r, RESP_OKAY, "strobe write");
			read_txn(k + 1, 8'h14, 0, d, r);
			check_data(d, model[5], "strobe read");
		end
		report_test("byte strobes", e0);
	endtask

	// 0xc4 would alias register 1 without the range check
	task automatic test_decode_err();
		int e0;
		data_t d;
		resp_t r;
		e0 = errs;
		write_txn(1, 8'hc4, rand_bits(32), 4'hf, r);
		verify_resp(r, RESP_SLVERR, "out of range write");
		read_txn(2, 8'h48, 0, d, r);
		check_data(d, '0, "out of range read");
		verify_resp(r, RESP_SLVERR, "out of range read");
		for (int i = 0; i < `LITE_REG_DEPTH; i++) begin
			read_txn(i % nm, addr_t'(4 * i), 0, d, r);
			check_data(d, model[i], "after decode error");
		end
		report_test("decode error", e0);
	endtask

	task automatic test_all_writers();
		int e0;
		data_t wd [nm];
		resp_t rs [nm];
		data_t d;
		resp_t r;
		port_idx_t first;
		e0 = errs;
		wr_order.delete();
		first = last_wr;
		for (int m = 0; m < nm; m++) begin
			wd[m] = rand_bits(32);
		end
		fork
			write_txn(0, 8'h18, wd[0], 4'hf, rs[0]);
			write_txn(1, 8'h18, wd[1], 4'hf, rs[1]);
			write_txn(2, 8'h18, wd[2], 4'hf, rs[2]);
			write_txn(3, 8'h18, wd[3], 4'hf, rs[3]);
		join
		for (int k = 0; k < nm; k++) begin
			expect_idx(wr_order[k], port_idx_t'(first + 1 + k), "b order");
			verify_resp(rs[k], RESP_OKAY, "contended write");
		end
		// full cycle of grants ends on the master granted before
		read_txn(0, 8'h18, 0, d, r);
		check_data(d, wd[first], "last granted writer");
		report_test("four writers", e0);
	endtask

	task automatic test_reads_stalled();
		int e0;
		data_t exp [nm];
		data_t got [nm];
		resp_t rr [nm];
		resp_t wr;
		data_t nd;
		port_idx_t first;
		time wr_done;
		e0 = errs;
		rd_order.delete();
		first = last_rd;
		for (int m = 0; m < nm; m++) begin
			exp[m] = model[8 + m];
		end
		nd = rand_bits(32);
		fork
			read_txn(0, 8'h20, 3, got[0], rr[0]);
			read_txn(1, 8'h24, 1, got[1], rr[1]);
			read_txn(2, 8'h28, 4, got[2], rr[2]);
			read_txn(3, 8'h2c, 2, got[3], rr[3]);
			begin
				write_txn(1, 8'h3c, nd, 4'hf, wr);
				wr_done = $time;
			end
		join
		for (int k = 0; k < nm; k++) begin
			expect_idx(rd_order[k], port_idx_t'(first + 1 + k), "r order");
			check_data(got[k], exp[k], "stalled read");
			verify_resp(rr[k], RESP_OKAY, "stalled read");
		end
		verify_resp(wr, RESP_OKAY, "write beside reads");
		if (wr_done >= $time) begin
			$display("write did not finish while the stalled reads were pending");
			errs++;
		end
		read_txn(0, 8'h3c, 0, got[0], rr[0]);
		check_data(got[0], nd, "write beside reads");
		report_test("stalled reads", e0);
	endtask

	initial begin
		rst_n = 1'b0;
		mst_req = '0;
		lfsr = 32'hf83;
		errs = 0;
		tests = 0;
		last_wr = '0;
		last_rd = '0;
		for (int i = 0; i < `LITE_REG_DEPTH; i++) begin
			model[i] = '0;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_fill();
		test_strobes();
		test_decode_err();
		test_all_writers();
		test_reads_stalled();
		$display("%0d tests run, %0d errors", tests, errs);
		if (errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+.
lite_pkg.sv
rr_sch.sv
wr_path.sv
rd_path.sv
reg_bank.sv
lite_arb_top.sv
tb_lite_arb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, exit status follows the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_lite_arb -f project.f || exit 1
out=$(./obj_dir/Vtb_lite_arb)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
